/* flist.f */
+incdir+rtl
rtl/taylor_pkg.sv
rtl/taylor_coef_rom.sv
rtl/mac_unit.sv
rtl/alu_taylor_calc.sv
rtl/taylor_wb_slave.sv
rtl/taylor_top.sv
verif/tb_clkgen.sv
verif/tb_taylor_top.sv

/* rtl/alu_taylor_calc.sv */
/* taylor series sequencer
   evaluates sin or cos in Horner form, one multiply-add request at a time */
`timescale 1ns/1ps
`default_nettype none
`include "taylor_config.svh"

module alu_taylor_calc (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 start,
    input  wire taylor_pkg::func_e              func,
    input  wire signed [`TAYLOR_DW-1:0]         x_in,
    output logic                                calc_done,
    output logic                                range_err,
    output logic signed [`TAYLOR_DW-1:0]        result,
    output logic [1:0]                          coef_term,
    input  wire signed [`TAYLOR_DW-1:0]         coef,
    output taylor_pkg::mac_req_t                mac_req,
    input  wire taylor_pkg::mac_rsp_t           mac_rsp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_SQUARE,
        ST_HORNER,
        ST_FINAL,
        ST_DONE
    } state_e;

    state_e                         state_q;
    taylor_pkg::func_e              func_q;
    logic signed [`TAYLOR_DW-1:0]   x_q;
    logic signed [`TAYLOR_DW-1:0]   y_q;        // x squared
    logic signed [`TAYLOR_DW-1:0]   acc_q;      // Horner accumulator
    logic [1:0]                     term_q;
    logic                           wait_q;     // request issued, response pending
    logic                           in_range;
    logic                           waiting;

    assign in_range  = (x_q <= `TAYLOR_X_LIMIT) && (x_q >= -`TAYLOR_X_LIMIT);
    assign coef_term = term_q;
    assign calc_done = (state_q == ST_DONE);
    assign waiting   = (state_q == ST_SQUARE) ||
                       (((state_q == ST_HORNER) || (state_q == ST_FINAL)) && wait_q);

    // request goes out in the first cycle of each step
    always_comb begin
        mac_req = '0;
        case (state_q)
            ST_CHECK: begin
                mac_req.valid = in_range;          // square x
                mac_req.a     = x_q;
                mac_req.b     = x_q;
            end
            ST_HORNER: begin
                mac_req.valid = !wait_q;
                mac_req.a     = acc_q;
                mac_req.b     = y_q;
                mac_req.c     = coef;
            end
            ST_FINAL: begin
                mac_req.valid = !wait_q;           // sine only, scale by x
                mac_req.a     = acc_q;
                mac_req.b     = x_q;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            term_q    <= '0;
            wait_q    <= 1'b0;
            range_err <= 1'b0;
            result    <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        term_q    <= 2'(`TAYLOR_TERMS - 1);
                        range_err <= 1'b0;
                        state_q   <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (!in_range) begin
                        range_err <= 1'b1;
                        result    <= '0;
                        state_q   <= ST_DONE;
                    end else begin
                        state_q   <= ST_SQUARE;
                    end
                end
                ST_SQUARE: begin
                    if (mac_rsp.valid) begin
                        term_q  <= term_q - 2'd1;
                        wait_q  <= 1'b0;
                        state_q <= ST_HORNER;
                    end
                end
                ST_HORNER: begin
                    if (!wait_q) begin
                        wait_q <= 1'b1;
                    end else if (mac_rsp.valid) begin
                        wait_q <= 1'b0;
                        if (term_q != 2'd0) begin
                            term_q <= term_q - 2'd1;
                        end else if (func_q == taylor_pkg::FUNC_SIN) begin
                            state_q <= ST_FINAL;
                        end else begin
                            result  <= mac_rsp.p;
                            state_q <= ST_DONE;
                        end
                    end
                end
                ST_FINAL: begin
                    if (!wait_q) begin
                        wait_q <= 1'b1;
                    end else if (mac_rsp.valid) begin
                        wait_q  <= 1'b0;
                        result  <= mac_rsp.p;
                        state_q <= ST_DONE;
                    end
                end
                default: state_q <= ST_IDLE;       // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && start) begin
            func_q <= func;
            x_q    <= x_in;
        end
        if (state_q == ST_SQUARE) begin
            acc_q <= coef;                         // preload c3 while squaring
            if (mac_rsp.valid)
                y_q <= mac_rsp.p;
        end
        if ((state_q == ST_HORNER) && mac_rsp.valid)
            acc_q <= mac_rsp.p;
    end

    // the register block must hold back a new job until this one is done
    assert property (@(posedge clk) disable iff (reset)
        start |-> (state_q == ST_IDLE));

    // the multiply-add unit answers only what was asked
    assert property (@(posedge clk) disable iff (reset)
        mac_rsp.valid |-> waiting);

endmodule

`default_nettype wire

/* rtl/mac_unit.sv */
/* multiply-add unit
   three-stage pipeline computing sat((a*b) >>> frac + c), no back-pressure */
`timescale 1ns/1ps
`default_nettype none
`include "taylor_config.svh"

module mac_unit (
    input  wire                         clk,
    input  wire                         reset,
    input  wire taylor_pkg::mac_req_t   req,
    output taylor_pkg::mac_rsp_t        rsp
);

    localparam int DW      = `TAYLOR_DW;
    localparam int FRAC    = `TAYLOR_FRAC;
    localparam int SAT_MAX = (1 << (DW - 1)) - 1;
    localparam int SAT_MIN = -(1 << (DW - 1));

    logic                         s1_valid, s2_valid, s3_valid;
    logic signed [DW-1:0]         s1_a, s1_b, s1_c;
    logic signed [DW-1:0]         s2_c;
    logic signed [2*DW-FRAC-1:0]  s2_prod;      // product after the fraction shift
    logic signed [DW-1:0]         s3_p;
    logic signed [2*DW-1:0]       product;
    logic signed [2*DW-FRAC:0]    sum;
    logic signed [DW-1:0]         sat;

    assign product = s1_a * s1_b;
    assign sum     = s2_prod + s2_c;

    always_comb begin
        if (sum > SAT_MAX)
            sat = DW'(SAT_MAX);
        else if (sum < SAT_MIN)
            sat = DW'(SAT_MIN);
        else
            sat = sum[DW-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_a    <= req.a;                       // stage 1: operand registers
        s1_b    <= req.b;
        s1_c    <= req.c;
        s2_prod <= product[2*DW-1:FRAC];        // stage 2: floor shift by frac bits
        s2_c    <= s1_c;
        s3_p    <= sat;                         // stage 3: add and clamp
    end

    assign rsp = {s3_valid, s3_p};

    // a request carries known operands
    assert property (@(posedge clk) disable iff (reset)
        req.valid |-> !$isunknown({req.a, req.b, req.c}));

endmodule

`default_nettype wire

/* rtl/taylor_coef_rom.sv */
/* taylor coefficient table
   Q2.16 coefficients of the sine and cosine series, by function and term */
`timescale 1ns/1ps
`default_nettype none
`include "taylor_config.svh"

module taylor_coef_rom (
    input  wire taylor_pkg::func_e          func,
    input  wire [1:0]                       term,
    output logic signed [`TAYLOR_DW-1:0]    coef
);

    always_comb begin
        if (func == taylor_pkg::FUNC_SIN) begin
            // sin(x) = x * (1 - y/6 + y^2/120 - y^3/5040), y = x^2
            case (term)
                2'd0:    coef = 18'sd65536;
                2'd1:    coef = -18'sd10923;
                2'd2:    coef = 18'sd546;
                default: coef = -18'sd13;
            endcase
        end else begin
            // cosine, also taken for the reserved codes
            case (term)
                2'd0:    coef = 18'sd65536;
                2'd1:    coef = -18'sd32768;     // -1/2
                2'd2:    coef = 18'sd2731;       // 1/24
                default: coef = -18'sd91;        // -1/720
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/taylor_config.svh */
/* taylor calculator configuration
   data format, engine timing and register map */
`ifndef TAYLOR_CONFIG_SVH
`define TAYLOR_CONFIG_SVH

// Q2.16 signed data
`define TAYLOR_DW       18
`define TAYLOR_FRAC     16
`define TAYLOR_TERMS    4          // polynomial coefficients c0..c3

`define TAYLOR_MAC_LAT  3          // multiply-add request to response
`define TAYLOR_X_LIMIT  102944     // pi/2 in Q2.16

// wishbone register offsets
`define TAYLOR_REG_CTRL    4'h0
`define TAYLOR_REG_X       4'h4
`define TAYLOR_REG_RESULT  4'h8
`define TAYLOR_REG_STATUS  4'hC

`endif

/* rtl/taylor_pkg.sv */
/* taylor calculator types
   function select, multiply-add request/response, wishbone bundles */
`default_nettype none
`include "taylor_config.svh"

package taylor_pkg;

    // codes 2 and 3 are reserved and behave as cosine
    typedef enum logic [1:0] {
        FUNC_SIN = 2'd0,
        FUNC_COS = 2'd1
    } func_e;

    typedef struct packed {
        logic                         valid;
        logic signed [`TAYLOR_DW-1:0] a;      // multiplicand
        logic signed [`TAYLOR_DW-1:0] b;      // multiplier
        logic signed [`TAYLOR_DW-1:0] c;      // addend
    } mac_req_t;

    typedef struct packed {
        logic                         valid;
        logic signed [`TAYLOR_DW-1:0] p;      // saturated a*b + c
    } mac_rsp_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;                   // valid with ack
    } wb_rsp_t;

endpackage

`default_nettype wire

/* rtl/taylor_top.sv */
/* taylor calculator top level
   wishbone register block, Horner sequencer, coefficient table and multiply-add unit */
`timescale 1ns/1ps
`default_nettype none
`include "taylor_config.svh"

module taylor_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire taylor_pkg::wb_req_t    wb_req,
    output taylor_pkg::wb_rsp_t         wb_rsp
);

    taylor_pkg::mac_req_t           mac_req;
    taylor_pkg::mac_rsp_t           mac_rsp;
    taylor_pkg::func_e              func;
    logic                           start;
    logic                           calc_done;
    logic                           range_err;
    logic signed [`TAYLOR_DW-1:0]   x_val;
    logic signed [`TAYLOR_DW-1:0]   result;
    logic signed [`TAYLOR_DW-1:0]   coef;
    logic [1:0]                     coef_term;

    taylor_wb_slave u_wb_slave (
        .clk        (clk        ),
        .reset      (reset      ),
        .wb_req     (wb_req     ),
        .wb_rsp     (wb_rsp     ),
        .start      (start      ),
        .func       (func       ),
        .x_val      (x_val      ),
        .calc_done  (calc_done  ),
        .range_err  (range_err  ),
        .result     (result     )
    );

    alu_taylor_calc u_calc (
        .clk        (clk        ),
        .reset      (reset      ),
        .start      (start      ),
        .func       (func       ),
        .x_in       (x_val      ),
        .calc_done  (calc_done  ),
        .range_err  (range_err  ),
        .result     (result     ),
        .coef_term  (coef_term  ),
        .coef       (coef       ),
        .mac_req    (mac_req    ),
        .mac_rsp    (mac_rsp    )
    );

    taylor_coef_rom u_coef_rom (
        .func       (func       ),      // held in the slave for the whole job
        .term       (coef_term  ),
        .coef       (coef       )
    );

    mac_unit u_mac (
        .clk        (clk        ),
        .reset      (reset      ),
        .req        (mac_req    ),
        .rsp        (mac_rsp    )
    );

endmodule

`default_nettype wire

/* rtl/taylor_wb_slave.sv */
/* wishbone classic register block
   control, angle, result and status registers of the taylor calculator */
`timescale 1ns/1ps
`default_nettype none
`include "taylor_config.svh"

module taylor_wb_slave (
    input  wire                             clk,
    input  wire                             reset,
    input  wire taylor_pkg::wb_req_t        wb_req,
    output taylor_pkg::wb_rsp_t             wb_rsp,
    output logic                            start,
    output taylor_pkg::func_e               func,
    output logic signed [`TAYLOR_DW-1:0]    x_val,
    input  wire                             calc_done,
    input  wire                             range_err,
    input  wire signed [`TAYLOR_DW-1:0]     result
);

    logic                           access;
    logic                           ack_q;
    logic [31:0]                    dat_r_q;
    logic                           busy_q;
    logic                           done_q;
    logic                           err_q;
    logic                           start_q;
    logic signed [`TAYLOR_DW-1:0]   result_q;
    taylor_pkg::func_e              func_q;
    logic signed [`TAYLOR_DW-1:0]   x_q;

    assign access = wb_req.cyc && wb_req.stb && !ack_q;   // first cycle of a request
    assign wb_rsp = {ack_q, dat_r_q};
    assign start  = start_q;
    assign func   = func_q;
    assign x_val  = x_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q    <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            err_q    <= 1'b0;
            start_q  <= 1'b0;
            result_q <= '0;
            func_q   <= taylor_pkg::FUNC_SIN;
            x_q      <= '0;
        end else begin
            ack_q   <= access;
            start_q <= 1'b0;
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    `TAYLOR_REG_CTRL: begin
                        // function is taken only with an accepted start
                        if (wb_req.dat_w[0] && !busy_q) begin
                            func_q  <= taylor_pkg::func_e'(wb_req.dat_w[2:1]);
                            start_q <= 1'b1;
                            busy_q  <= 1'b1;
                            done_q  <= 1'b0;
                            err_q   <= 1'b0;
                        end
                    end
                    `TAYLOR_REG_X: x_q <= wb_req.dat_w[`TAYLOR_DW-1:0];
                    default: ;
                endcase
            end
            if (calc_done) begin
                busy_q   <= 1'b0;
                done_q   <= 1'b1;
                err_q    <= range_err;
                result_q <= result;              // zero on range error
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_req.we) begin
            case (wb_req.adr)
                `TAYLOR_REG_X:      dat_r_q <= {{(32-`TAYLOR_DW){x_q[`TAYLOR_DW-1]}}, x_q};
                `TAYLOR_REG_RESULT: dat_r_q <= {{(32-`TAYLOR_DW){result_q[`TAYLOR_DW-1]}},
                                                result_q};
                `TAYLOR_REG_STATUS: dat_r_q <= {29'd0, err_q, done_q, busy_q};
                default:            dat_r_q <= '0;   // ctrl is write only
            endcase
        end
    end

    // completions arrive only for a job this block started
    assert property (@(posedge clk) disable iff (reset)
        calc_done |-> busy_q);

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
/* testbench clock and reset
   8 ns clock, synchronous reset held for the first 8 cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 4;        // ns
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;                    // release just after the edge
    end

endmodule

`default_nettype wire

/* verif/tb_taylor_top.sv */
/* taylor calculator testbench
   directed jobs over the wishbone port, checked against a Q2.16 Horner model */
`timescale 1ns/1ps
`default_nettype none
`include "taylor_config.svh"

module tb_taylor_top;

    localparam int NUM_JOBS        = 116;
    localparam int WATCHDOG_CYCLES = 200 * NUM_JOBS + 1000;
    localparam int BUS_WAIT_MAX    = 16;
    localparam int POLL_MAX        = 100;
    localparam int SAT_MAX         = (1 << (`TAYLOR_DW - 1)) - 1;
    localparam int SAT_MIN         = -(1 << (`TAYLOR_DW - 1));
    localparam int FSEL_SIN        = 0;
    localparam int FSEL_COS        = 1;

    logic                   clk;
    logic                   reset;
    taylor_pkg::wb_req_t    wb_req;
    taylor_pkg::wb_rsp_t    wb_rsp;
    integer                 seed;

    tb_clkgen u_clkgen (
        .clk    (clk   ),
        .reset  (reset )
    );

    taylor_top uut (
        .clk    (clk   ),
        .reset  (reset ),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s, read %0d, expected %0d",
                     $time, what, $signed(got), $signed(exp));
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // sat((a*b) >>> 16 + c), truncating shift
    function automatic int mac_ref(input int a, input int b, input int c);
        longint prod;
        longint sum;
        prod = (longint'(a) * longint'(b)) >>> `TAYLOR_FRAC;
        sum  = prod + longint'(c);
        if (sum > SAT_MAX)
            return SAT_MAX;
        else if (sum < SAT_MIN)
            return SAT_MIN;
        return int'(sum);
    endfunction

    function automatic int coef_ref(input int fsel, input int term);
        if (fsel == FSEL_SIN) begin
            case (term)
                0:       return 65536;
                1:       return -10923;
                2:       return 546;
                default: return -13;
            endcase
        end
        case (term)                                 // cosine and reserved codes
            0:       return 65536;
            1:       return -32768;
            2:       return 2731;
            default: return -91;
        endcase
    endfunction

    function automatic int taylor_ref(input int fsel, input int x);
        int y;
        int acc;
        int t;
        if ((x > `TAYLOR_X_LIMIT) || (x < -`TAYLOR_X_LIMIT))
            return 0;
        y   = mac_ref(x, x, 0);
        acc = coef_ref(fsel, 3);
        for (t = 2; t >= 0; t--)
            acc = mac_ref(acc, y, coef_ref(fsel, t));
        if (fsel == FSEL_SIN)
            return mac_ref(acc, x, 0);
        return acc;
    endfunction

    task automatic wait_ack();
        int waits;
        waits = 0;
        @(posedge clk);
        #1;
        while (!wb_rsp.ack) begin
            assert (waits < BUS_WAIT_MAX) else begin
                $display("bus slave gave no acknowledge within %0d cycles at %0t",
                         BUS_WAIT_MAX, $time);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            waits++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        @(posedge clk);
        #1;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = adr;
        wb_req.dat_w = data;
        wait_ack();
        wb_req = '0;                                // end of the classic cycle
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wait_ack();
        data   = wb_rsp.dat_r;                      // valid with ack
        wb_req = '0;
    endtask

    task automatic wait_done(output logic [31:0] status);
        int polls;
        polls = 0;
        wb_read(`TAYLOR_REG_STATUS, status);
        while (!status[1]) begin
            assert (polls < POLL_MAX) else begin
                $display("job did not report done after %0d status polls", POLL_MAX);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end
            polls++;
            wb_read(`TAYLOR_REG_STATUS, status);
        end
    endtask

    task automatic run_job(input int fsel, input int x, input bit expect_busy,
                           output logic [31:0] status, output logic [31:0] result);
        logic [31:0] busy_status;
        wb_write(`TAYLOR_REG_X, 32'(x));
        wb_write(`TAYLOR_REG_CTRL, 32'((fsel << 1) | 1));
        if (expect_busy) begin
            wb_read(`TAYLOR_REG_STATUS, busy_status);
            check_value("busy while job runs", {31'd0, busy_status[0]}, 32'd1);
        end
        wait_done(status);
        wb_read(`TAYLOR_REG_RESULT, result);
    endtask

    task automatic expect_job(input int fsel, input int x, input bit expect_busy);
        logic [31:0] status;
        logic [31:0] result;
        run_job(fsel, x, expect_busy, status, result);
        check_value($sformatf("result of func %0d at x=%0d", fsel, x), result,
                    32'(taylor_ref(fsel, x)));
        check_value("status after job", status, 32'h2);     // done only
    endtask

    task automatic reset_values();
        logic [31:0] data;
        wb_read(`TAYLOR_REG_STATUS, data);
        check_value("status after reset", data, 32'd0);
        wb_read(`TAYLOR_REG_RESULT, data);
        check_value("result after reset", data, 32'd0);
    endtask

    task automatic sine_points();
        expect_job(FSEL_SIN, 0, 1'b0);
        expect_job(FSEL_SIN, `TAYLOR_X_LIMIT, 1'b0);
        expect_job(FSEL_SIN, -`TAYLOR_X_LIMIT, 1'b0);
    endtask

    task automatic cosine_points();
        int code;
        for (code = FSEL_COS; code <= 3; code++) begin     // 2 and 3 are reserved
            expect_job(code, 0, 1'b0);
            expect_job(code, `TAYLOR_X_LIMIT, 1'b0);
            expect_job(code, -`TAYLOR_X_LIMIT, 1'b0);
        end
    endtask

    task automatic random_angles();
        int i;
        int x;
        for (i = 0; i < 50; i++) begin
            x = $random(seed) % (`TAYLOR_X_LIMIT + 1);
            expect_job(FSEL_SIN, x, 1'b1);
            x = $random(seed) % (`TAYLOR_X_LIMIT + 1);
            expect_job(FSEL_COS, x, 1'b1);
        end
    endtask

    task automatic range_errors();
        logic [31:0] status;
        logic [31:0] result;
        run_job(FSEL_SIN, 110000, 1'b0, status, result);
        check_value("status for x=110000", status, 32'h6);  // done and range_err
        check_value("result for x=110000", result, 32'd0);
        run_job(FSEL_COS, -110000, 1'b0, status, result);
        check_value("status for x=-110000", status, 32'h6);
        check_value("result for x=-110000", result, 32'd0);
        expect_job(FSEL_COS, 5000, 1'b0);                   // clears range_err
    endtask

    task automatic start_while_busy();
        logic [31:0] status;
        logic [31:0] result;
        logic [31:0] angle;
        wb_write(`TAYLOR_REG_X, 32'(40000));
        wb_write(`TAYLOR_REG_CTRL, 32'((FSEL_SIN << 1) | 1));
        wb_write(`TAYLOR_REG_X, 32'(-70000));
        wb_write(`TAYLOR_REG_CTRL, 32'((FSEL_COS << 1) | 1));   // dropped, job still busy
        wait_done(status);
        wb_read(`TAYLOR_REG_RESULT, result);
        check_value("result after ignored start", result, 32'(taylor_ref(FSEL_SIN, 40000)));
        check_value("status after ignored start", status, 32'h2);
        wb_read(`TAYLOR_REG_X, angle);
        check_value("angle written while busy", angle, 32'(-70000));
    endtask

    initial begin
        seed   = 13277;
        wb_req = '0;
        wait (reset === 1'b0);
        reset_values();
        sine_points();
        cosine_points();
        random_angles();
        range_errors();
        start_while_busy();
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire
